// ==== hw/fb_pkg.sv ====
package fb_pkg;

    //------------------------------------------------------------------------
    // screen geometry
    //------------------------------------------------------------------------
    localparam int h_disp    = 16;                   // pixels per line
    localparam int v_disp    = 8;                    // lines per frame
    localparam int buf_words = h_disp * v_disp;      // pixels per buffer

    localparam int x_w = $clog2(h_disp);             // column index bits
    localparam int y_w = $clog2(v_disp);             // line index bits

    //------------------------------------------------------------------------
    // widths
    //------------------------------------------------------------------------
    localparam int addr_w  = 8;                      // msb picks the buffer
    localparam int coord_w = 16;                     // host x/y width
    localparam int len_w   = 24;                     // host run length width

    typedef logic [23:0] pixel_t;                    // rgb 8:8:8

    // host opcodes
    typedef enum logic [1:0] {
        op_run   = 2'd0,                             // horizontal run at x,y
        op_clear = 2'd1,                             // fill whole back buffer
        op_swap  = 2'd2                              // exchange front/back
    } draw_op_e;

    // execute stage FSM
    typedef enum logic [1:0] {
        st_idle      = 2'd0,                         // waiting for a job
        st_write     = 2'd1,                         // one pixel per cycle
        st_swap_wait = 2'd2                          // waiting on scanout ack
    } exec_state_e;

endpackage

// ==== hw/draw_job_if.sv ====
`timescale 1ns/1ps
interface draw_job_if
    import fb_pkg::*;
();

    logic               valid;          // job presented
    logic               ready;          // execute idle
    draw_op_e           op;             // what to do
    logic [addr_w-1:0]  start_addr;     // first pixel, buffer bit included
    logic [addr_w-1:0]  count;          // pixels to write, 0 = none
    pixel_t             color;          // fill colour

    // decode side
    modport src (
        output valid, op, start_addr, count, color,
        input  ready
    );

    // execute side
    modport dst (
        input  valid, op, start_addr, count, color,
        output ready
    );

endinterface

// ==== hw/draw_decode.sv ====
`timescale 1ns/1ps
module draw_decode
    import fb_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                enable,         // host command strobe
    input  draw_op_e            op,
    input  logic [coord_w-1:0]  x_pos,
    input  logic [coord_w-1:0]  y_pos,
    input  logic [len_w-1:0]    len,
    input  pixel_t              pixel,
    input  logic                front_sel,      // from scanout
    input  logic                job_done,       // from execute
    output logic                busy,
    draw_job_if.src             job
);

    logic                accept;        // command taken this edge
    logic                x_on;
    logic                y_on;
    logic [coord_w-1:0]  room;          // pixels left on the line
    logic [len_w-1:0]    run_len;       // len clipped to line end
    logic [addr_w-1:0]   run_cnt;
    logic [addr_w-1:0]   back_base;     // first word of back buffer
    logic [addr_w-1:0]   pix_off;       // y*h_disp + x

    assign accept = enable && !busy;

    //------------------------------------------------------------------------
    // clipping and addressing
    //------------------------------------------------------------------------
    assign x_on    = x_pos < coord_w'(h_disp);
    assign y_on    = y_pos < coord_w'(v_disp);
    assign room    = coord_w'(h_disp) - x_pos;  // only meaningful when x_on
    assign run_len = (len < len_w'(room)) ? len : len_w'(room);
    assign run_cnt = (x_on && y_on) ? run_len[addr_w-1:0] : '0;  // off screen -> nothing

    // back buffer is the one scanout is not showing
    assign back_base = front_sel ? '0 : addr_w'(buf_words);
    // h_disp is a power of two so the product is a plain bit join
    assign pix_off   = addr_w'({y_pos[y_w-1:0], x_pos[x_w-1:0]});

    //------------------------------------------------------------------------
    // busy and job valid
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            job.valid <= 1'b0;
        end else begin
            if (accept) begin
                busy      <= 1'b1;              // high from next cycle
                job.valid <= 1'b1;              // job one cycle after accept
            end else begin
                if (job.valid && job.ready)
                    job.valid <= 1'b0;          // handed over
                if (job_done)
                    busy <= 1'b0;               // execute finished
            end
        end
    end

    // job payload, captured once per command
    always_ff @(posedge clk) begin
        if (accept) begin
            job.op    <= op;
            job.color <= pixel;
            case (op)
                op_run: begin
                    job.start_addr <= back_base + pix_off;
                    job.count      <= run_cnt;
                end
                op_clear: begin
                    job.start_addr <= back_base;
                    job.count      <= addr_w'(buf_words);   // whole buffer
                end
                default: begin                  // swap, no pixel writes
                    job.start_addr <= back_base;
                    job.count      <= '0;
                end
            endcase
        end
    end

endmodule

// ==== hw/draw_execute.sv ====
`timescale 1ns/1ps
module draw_execute
    import fb_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    draw_job_if.dst             job,
    output logic                we,             // frame memory write
    output logic [addr_w-1:0]   waddr,
    output pixel_t              wdata,
    output logic                swap_req,       // held until ack
    input  logic                swap_ack,       // one cycle from scanout
    output logic                job_done        // one cycle per job
);

    exec_state_e        state;
    logic [addr_w-1:0]  remain;         // writes still to issue
    logic               take;           // job transfer this edge

    assign job.ready = (state == st_idle);
    assign take      = job.valid && job.ready;

    //------------------------------------------------------------------------
    // FSM
    //------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= st_idle;
            we       <= 1'b0;
            swap_req <= 1'b0;
            job_done <= 1'b0;
            remain   <= '0;
        end else begin
            job_done <= 1'b0;                   // pulse by default
            case (state)
                st_idle: begin
                    if (take) begin
                        if (job.op == op_swap) begin
                            swap_req <= 1'b1;
                            state    <= st_swap_wait;
                        end else if (job.count == '0) begin
                            job_done <= 1'b1;   // clipped away, nothing to write
                        end else begin
                            we     <= 1'b1;     // first write next cycle
                            remain <= job.count;
                            state  <= st_write;
                        end
                    end
                end
                st_write: begin
                    remain <= remain - addr_w'(1);
                    if (remain == addr_w'(1)) begin
                        we       <= 1'b0;       // last one went out
                        job_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                st_swap_wait: begin
                    if (swap_ack) begin         // scanout flipped at frame end
                        swap_req <= 1'b0;
                        job_done <= 1'b1;
                        state    <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // write address walks up, colour stays for the whole job
    always_ff @(posedge clk) begin
        if (take) begin
            waddr <= job.start_addr;
            wdata <= job.color;
        end else if (state == st_write) begin
            waddr <= waddr + addr_w'(1);
        end
    end

endmodule

// ==== hw/frame_mem.sv ====
`timescale 1ns/1ps
module frame_mem
    import fb_pkg::*;
(
    input  logic                clk,
    input  logic                we,
    input  logic [addr_w-1:0]   waddr,
    input  pixel_t              wdata,
    input  logic [addr_w-1:0]   raddr,
    output pixel_t              rdata           // one cycle after raddr
);

    // buffer 0 in the low half, buffer 1 in the high half
    pixel_t mem [2*buf_words];

    // write port, from execute
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // registered read port, from scanout
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// ==== hw/scanout.sv ====
`timescale 1ns/1ps
module scanout
    import fb_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    output logic [addr_w-1:0]   raddr,
    input  pixel_t              rdata,
    input  logic                swap_req,
    output logic                swap_ack,       // pulses as front_sel flips
    output logic                front_sel,      // buffer being shown
    output logic                out_valid,
    output pixel_t              out_pixel,
    output logic                out_sof,        // first pixel of frame
    output logic                out_eol,        // last pixel of line
    input  logic                out_ready
);

    logic [x_w-1:0]  x_cnt;
    logic [y_w-1:0]  y_cnt;
    logic            rd_pend;           // rdata valid this cycle
    logic            rd_sof;
    logic            rd_eol;
    logic            hold_valid;        // skid slot behind output reg
    pixel_t          hold_pixel;
    logic            hold_sof;
    logic            hold_eol;
    logic            pop;               // output pixel taken
    logic [1:0]      fill;              // slots used next cycle, reads in flight included
    logic            issue;             // start a read now
    logic            last_pix;
    logic            out_load;          // output reg takes a new entry
    logic            hold_load;         // rdata parks in skid slot

    //------------------------------------------------------------------------
    // read issue
    //------------------------------------------------------------------------
    assign pop      = out_valid && out_ready;
    assign fill     = 2'(out_valid) + 2'(hold_valid) + 2'(rd_pend) - 2'(pop);
    assign issue    = fill < 2'd2;      // only read what can be stored
    assign last_pix = (x_cnt == x_w'(h_disp - 1)) && (y_cnt == y_w'(v_disp - 1));
    assign raddr    = {front_sel, y_cnt, x_cnt};    // base + y*h_disp + x

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            x_cnt     <= '0;
            y_cnt     <= '0;
            front_sel <= 1'b0;
            swap_ack  <= 1'b0;
            rd_pend   <= 1'b0;
            rd_sof    <= 1'b0;
            rd_eol    <= 1'b0;
        end else begin
            rd_pend  <= issue;
            rd_sof   <= issue && (x_cnt == '0) && (y_cnt == '0);
            rd_eol   <= issue && (x_cnt == x_w'(h_disp - 1));
            swap_ack <= 1'b0;
            if (issue) begin
                x_cnt <= x_cnt + x_w'(1);       // wraps at line end
                if (x_cnt == x_w'(h_disp - 1))
                    y_cnt <= y_cnt + y_w'(1);
                // frame boundary, take a pending swap here only
                if (last_pix && swap_req) begin
                    front_sel <= ~front_sel;
                    swap_ack  <= 1'b1;
                end
            end
        end
    end

    //------------------------------------------------------------------------
    // output register plus skid slot
    //------------------------------------------------------------------------
    assign out_load  = !out_valid || out_ready;
    assign hold_load = rd_pend && (out_load ? hold_valid : 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid  <= 1'b0;
            out_sof    <= 1'b0;
            out_eol    <= 1'b0;
            hold_valid <= 1'b0;
            hold_sof   <= 1'b0;
            hold_eol   <= 1'b0;
        end else begin
            if (out_load) begin                 // skid slot drains first
                out_valid <= hold_valid || rd_pend;
                out_sof   <= hold_valid ? hold_sof : rd_sof;
                out_eol   <= hold_valid ? hold_eol : rd_eol;
            end
            if (hold_load) begin
                hold_sof <= rd_sof;
                hold_eol <= rd_eol;
            end
            hold_valid <= hold_load || (hold_valid && !out_load);
        end
    end

    // pixel data follows the flags above
    always_ff @(posedge clk) begin
        if (out_load)
            out_pixel <= hold_valid ? hold_pixel : rdata;
        if (hold_load)
            hold_pixel <= rdata;
    end

endmodule

// ==== hw/fb_draw_top.sv ====
`timescale 1ns/1ps
module fb_draw_top
    import fb_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    // host command port
    input  logic                enable,
    input  draw_op_e            op,
    input  logic [coord_w-1:0]  x_pos,
    input  logic [coord_w-1:0]  y_pos,
    input  logic [len_w-1:0]    len,
    input  pixel_t              pixel,
    output logic                busy,
    // pixel stream out
    output logic                out_valid,
    output pixel_t              out_pixel,
    output logic                out_sof,
    output logic                out_eol,
    input  logic                out_ready
);

    logic               front_sel;
    logic               job_done;
    logic               swap_req;
    logic               swap_ack;
    logic               we;
    logic [addr_w-1:0]  waddr;
    pixel_t             wdata;
    logic [addr_w-1:0]  raddr;
    pixel_t             rdata;

    draw_job_if job_bus ();             // decode -> execute

    //------------------------------------------------------------------------
    // stages
    //------------------------------------------------------------------------
    draw_decode u_draw_decode (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .op         (op),
        .x_pos      (x_pos),
        .y_pos      (y_pos),
        .len        (len),
        .pixel      (pixel),
        .front_sel  (front_sel),
        .job_done   (job_done),
        .busy       (busy),
        .job        (job_bus.src)
    );

    draw_execute u_draw_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .job        (job_bus.dst),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .swap_req   (swap_req),
        .swap_ack   (swap_ack),
        .job_done   (job_done)
    );

    frame_mem u_frame_mem (
        .clk        (clk),
        .we         (we),
        .waddr      (waddr),
        .wdata      (wdata),
        .raddr      (raddr),
        .rdata      (rdata)
    );

    scanout u_scanout (
        .clk        (clk),
        .rst_n      (rst_n),
        .raddr      (raddr),
        .rdata      (rdata),
        .swap_req   (swap_req),
        .swap_ack   (swap_ack),
        .front_sel  (front_sel),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_sof    (out_sof),
        .out_eol    (out_eol),
        .out_ready  (out_ready)
    );

endmodule

// ==== bench/tb_fb_draw.sv ====
`timescale 1ns/1ps
module tb_fb_draw
    import fb_pkg::*;
();

    logic                clk;
    logic                rst_n;
    logic                enable;
    draw_op_e            op;
    logic [coord_w-1:0]  x_pos;
    logic [coord_w-1:0]  y_pos;
    logic [len_w-1:0]    len;
    pixel_t              pixel;
    logic                busy;
    logic                out_valid;
    pixel_t              out_pixel;
    logic                out_sof;
    logic                out_eol;
    logic                out_ready;

    pixel_t  mdl [0:2*buf_words-1];     // reference copy of both buffers
    logic    mdl_front;                 // buffer the model says is shown
    pixel_t  cap [0:buf_words-1];       // last captured frame
    int      cap_n;                     // pixels captured so far
    int      errors;
    int      test_errs;
    int      tests;
    int      tests_bad;
    bit      aborted;                   // set when a wait ran out

    fb_draw_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .enable     (enable),
        .op         (op),
        .x_pos      (x_pos),
        .y_pos      (y_pos),
        .len        (len),
        .pixel      (pixel),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_sof    (out_sof),
        .out_eol    (out_eol),
        .out_ready  (out_ready)
    );

    always #4 clk = ~clk;               // 8 ns period

    // random back-pressure with ready about 3 cycles in 4
    always @(posedge clk) begin
        #1;
        out_ready = ($urandom % 4) != 0;
    end

    //------------------------------------------------------------------------
    // failure reporting
    //------------------------------------------------------------------------
    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
        test_errs++;
    endtask

    task automatic halt_sequence(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);    // stops the pattern run
        errors++;
        test_errs++;
        aborted = 1'b1;
    endtask

    task automatic finish_test(input string name);
        if (name.len() > 0) begin
            tests++;
            if (test_errs == 0) begin
                $display("test %s: ok", name);
            end else begin
                $display("test %s: %0d errors", name, test_errs);
                tests_bad++;
            end
        end
        test_errs = 0;
    endtask

    //------------------------------------------------------------------------
    // reference model of both buffers
    //------------------------------------------------------------------------
    task automatic model_apply(input draw_op_e c_op, input int xi, input int yi,
                               input int li, input pixel_t cc);
        int base;
        int cnt;
        base = mdl_front ? 0 : buf_words;   // always the back buffer
        if (c_op == op_clear) begin
            for (int i = 0; i < buf_words; i++)
                mdl[base + i] = cc;
        end else if (c_op == op_run && xi < h_disp && yi < v_disp) begin
            cnt = (li < h_disp - xi) ? li : h_disp - xi;    // stop at line end
            for (int i = 0; i < cnt; i++)
                mdl[base + yi * h_disp + xi + i] = cc;
        end
    endtask

    //------------------------------------------------------------------------
    // host side
    //------------------------------------------------------------------------
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy && n < 4000) begin
            @(negedge clk);
            n++;
        end
        if (busy)
            halt_sequence("busy stayed high, command never finished");
    endtask

    task automatic send_cmd(input draw_op_e c_op, input logic [coord_w-1:0] cx,
                            input logic [coord_w-1:0] cy, input logic [len_w-1:0] cl,
                            input pixel_t cc);
        if (aborted)
            return;
        wait_idle();
        if (aborted)
            return;
        @(posedge clk);
        #1;
        enable = 1'b1;
        op     = c_op;
        x_pos  = cx;
        y_pos  = cy;
        len    = cl;
        pixel  = cc;
        @(posedge clk);                 // accepted here
        #1;
        if (busy !== 1'b1)
            report_mismatch("busy not high the cycle after accept");
        op    = op_clear;               // stray strobe while busy must be dropped
        pixel = 24'hffffff;
        @(posedge clk);
        #1;
        enable = 1'b0;
        model_apply(c_op, int'(cx), int'(cy), int'(cl), cc);
        wait_idle();
        if (c_op == op_swap && !aborted)
            mdl_front = ~mdl_front;     // busy low means the flip happened
    endtask

    task automatic random_runs(input int n);
        for (int i = 0; i < n; i++)
            send_cmd(op_run, coord_w'($urandom % 20), coord_w'($urandom % 10),
                     len_w'($urandom % 20), pixel_t'($urandom));
    endtask

    //------------------------------------------------------------------------
    // stream side sampled on the falling edge
    //------------------------------------------------------------------------
    task automatic capture_frame();
        int n;
        cap_n = 0;
        n = 0;
        @(negedge clk);
        while (!(out_valid && out_ready && out_sof) && n < 2000) begin
            @(negedge clk);
            n++;
        end
        if (!(out_valid && out_ready && out_sof)) begin
            halt_sequence("no start of frame seen on the output stream");
            return;
        end
        while (cap_n < buf_words) begin
            if (out_sof !== (cap_n == 0))
                report_mismatch($sformatf("out_sof wrong at pixel %0d", cap_n));
            if (out_eol !== (cap_n % h_disp == h_disp - 1))
                report_mismatch($sformatf("out_eol wrong at pixel %0d", cap_n));
            cap[cap_n] = out_pixel;
            cap_n++;
            if (cap_n < buf_words) begin
                n = 0;
                @(negedge clk);
                while (!(out_valid && out_ready) && n < 200) begin
                    @(negedge clk);
                    n++;
                end
                if (!(out_valid && out_ready)) begin
                    halt_sequence("output stream stalled inside a frame");
                    return;
                end
            end
        end
        // next transfer must open a new frame
        n = 0;
        @(negedge clk);
        while (!(out_valid && out_ready) && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!(out_valid && out_ready))
            halt_sequence("output stream stalled after a frame");
        else if (out_sof !== 1'b1)
            report_mismatch("frame longer than h_disp * v_disp pixels");
    endtask

    task automatic check_frame(input logic shown);
        int base;
        base = shown ? buf_words : 0;
        for (int i = 0; i < buf_words; i++) begin
            if (cap[i] !== mdl[base + i])
                report_mismatch($sformatf("frame pixel (%0d,%0d) got %h expected %h",
                                          i % h_disp, i / h_disp, cap[i], mdl[base + i]));
        end
    endtask

    task automatic check_pixel(input int px, input int py, input pixel_t want);
        int idx;
        idx = py * h_disp + px;
        if (cap_n != buf_words || idx >= buf_words) begin
            halt_sequence("expect record without a full captured frame");
        end else if (cap[idx] !== want) begin
            report_mismatch($sformatf("pixel (%0d,%0d) got %h expected %h",
                                      px, py, cap[idx], want));
        end
    endtask

    // swap issued partway through a frame leaves that frame on the old buffer
    task automatic swap_mid_frame();
        logic shown;
        int   n;
        shown = mdl_front;
        cap_n = 0;
        n     = 0;
        fork
            capture_frame();
            begin
                while (cap_n < 40 && n < 2000 && !aborted) begin
                    @(negedge clk);
                    n++;
                end
                if (cap_n < 40 && !aborted)
                    halt_sequence("capture never reached the middle of a frame");
                send_cmd(op_swap, '0, '0, '0, '0);
            end
        join
        if (!aborted)
            check_frame(shown);
    endtask

    //------------------------------------------------------------------------
    // main sequence driven from the pattern file
    //------------------------------------------------------------------------
    initial begin
        int          fd;
        int          got;
        string       line;
        string       kind;
        string       name;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;

        clk       = 1'b0;
        rst_n     = 1'b0;
        enable    = 1'b0;
        op        = op_run;
        x_pos     = '0;
        y_pos     = '0;
        len       = '0;
        pixel     = '0;
        out_ready = 1'b0;
        mdl_front = 1'b0;
        cap_n     = 0;
        errors    = 0;
        test_errs = 0;
        tests     = 0;
        tests_bad = 0;
        aborted   = 1'b0;
        name      = "";
        void'($urandom(85000));

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        if (busy !== 1'b0)
            report_mismatch("busy high after reset");

        fd = $fopen("bench/draw_patterns.txt", "r");
        if (fd == 0)
            halt_sequence("cannot open bench/draw_patterns.txt");
        while (fd != 0 && !aborted && !$feof(fd)) begin
            kind = "";
            got  = $fgets(line, fd);
            if (got > 0)
                got = $sscanf(line, "%s %h %h %h %h %h", kind, f1, f2, f3, f4, f5);
            if (kind == "T") begin
                finish_test(name);
                got = $sscanf(line, "%s %s", kind, name);
            end else if (kind == "C") begin
                send_cmd(draw_op_e'(f1[1:0]), f2[15:0], f3[15:0], f4[23:0], f5[23:0]);
            end else if (kind == "F") begin
                capture_frame();
                if (!aborted)
                    check_frame(mdl_front);
            end else if (kind == "E") begin
                check_pixel(int'(f1), int'(f2), f3[23:0]);
            end else if (kind == "M") begin
                swap_mid_frame();
            end else if (kind == "X") begin
                random_runs(int'(f1));
            end
        end
        if (fd != 0)
            $fclose(fd);
        finish_test(name);

        $display("tests %0d, failed %0d, errors %0d", tests, tests_bad, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== bench/draw_patterns.txt ====
# kind then hex fields. C op x y len colour (op 0 run, 1 clear, 2 swap)
# F captures a frame, E x y colour checks it, M swaps mid-frame, X n random runs
T init
C 1 0 0 0 000000
C 2 0 0 0 000000
C 1 0 0 0 000000
T clear_swap
C 1 0 0 0 aa0000
C 2 0 0 0 000000
C 1 0 0 0 00bb00
F
E 0 0 aa0000
C 2 0 0 0 000000
F
E f 7 00bb00
T runs_clip
C 0 2 1 4 123456
C 0 c 3 a abcdef
C 0 14 2 3 ffffff
C 0 1 9 3 ffffff
C 0 3 4 0 ffffff
C 2 0 0 0 000000
F
E 1 1 aa0000
E 2 1 123456
E 5 1 123456
E 6 1 aa0000
E b 3 aa0000
E c 3 abcdef
E f 3 abcdef
E 0 4 aa0000
E 3 4 aa0000
T mid_swap
M
F
E 3 3 00bb00
T stress
X 18
C 2 0 0 0 000000
F
X 18
C 2 0 0 0 000000
F

// ==== verilog.f ====
hw/fb_pkg.sv
hw/draw_job_if.sv
hw/draw_decode.sv
hw/draw_execute.sv
hw/frame_mem.sv
hw/scanout.sv
hw/fb_draw_top.sv
bench/tb_fb_draw.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = tb_fb_draw
FILELIST = verilog.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
